//--- common/cop_pkg.sv
// Coprocessor shared definitions
package cop_pkg;

    localparam int xlen  = 32;
    localparam int ncreg = 16;              // Coprocessor register count

    typedef logic [xlen-1:0] word_t;
    typedef logic [3:0]      creg_t;
    typedef logic [2:0]      pw_t;
    typedef logic [3:0]      funct_t;
    typedef logic [4:0]      imm_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [7:0]      apb_addr_t;
    typedef logic [4:0]      pack_mask_t;   // One enable bit per pack width code

    localparam opcode_t op_custom = 7'b0001011;

    // Instruction word field positions
    localparam int opcode_hi = 6;
    localparam int opcode_lo = 0;
    localparam int crd_hi    = 10;
    localparam int crd_lo    = 7;
    localparam int rsvd_bit  = 11;          // Must be zero
    localparam int pw_hi     = 14;
    localparam int pw_lo     = 12;
    localparam int crs1_hi   = 18;
    localparam int crs1_lo   = 15;
    localparam int crs2_hi   = 22;
    localparam int crs2_lo   = 19;
    localparam int imm_hi    = 27;
    localparam int imm_lo    = 23;
    localparam int funct_hi  = 31;
    localparam int funct_lo  = 28;

    // Function codes 0 to 9 are legal
    localparam funct_t f_padd    = 4'd0;
    localparam funct_t f_psub    = 4'd1;
    localparam funct_t f_psll_i  = 4'd2;
    localparam funct_t f_psrl_i  = 4'd3;
    localparam funct_t f_prot_i  = 4'd4;
    localparam funct_t f_bop     = 4'd5;
    localparam funct_t f_gpr2xcr = 4'd6;
    localparam funct_t f_xcr2gpr = 4'd7;
    localparam funct_t f_cmov    = 4'd8;
    localparam funct_t f_cmovn   = 4'd9;

    // Pack width codes
    localparam pw_t pw_32 = 3'd0;
    localparam pw_t pw_16 = 3'd1;
    localparam pw_t pw_8  = 3'd2;
    localparam pw_t pw_4  = 3'd3;
    localparam pw_t pw_2  = 3'd4;           // Highest legal code

    localparam pack_mask_t pack_mask_all = 5'b11111;

    // APB register map
    localparam apb_addr_t addr_insn      = 8'h00;
    localparam apb_addr_t addr_gpr_in    = 8'h04;
    localparam apb_addr_t addr_gpr_out   = 8'h08;
    localparam apb_addr_t addr_status    = 8'h0C;
    localparam apb_addr_t addr_creg_base = 8'h40;  // Sixteen words

    typedef struct packed {
        logic   valid;
        funct_t funct;
        pw_t    pw;
        creg_t  crd;
        creg_t  crs1;
        creg_t  crs2;
        imm_t   imm;
        logic   exception;
    } decoded_t;

    typedef struct packed {
        logic  valid;
        logic  creg_we;
        creg_t crd;
        word_t data;
        logic  gpr_we;
        word_t gpr_data;
        logic  exception;
    } wb_t;

endpackage

//--- source/cop_apb_port.sv
// APB host port
module cop_apb_port (
    input  logic               g_clk,
    input  logic               reset,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  cop_pkg::apb_addr_t paddr,
    input  cop_pkg::word_t     pwdata,
    output cop_pkg::word_t     prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               insn_valid,
    output cop_pkg::word_t     insn,
    output cop_pkg::word_t     gpr_in,
    output cop_pkg::creg_t     dbg_addr,
    input  logic               done,
    input  logic               exception,
    input  cop_pkg::word_t     gpr_out,
    input  cop_pkg::word_t     dbg_data
);

    typedef enum logic {
        st_idle,
        st_wait_done
    } state_t;

    state_t state;
    logic   access;           // First access cycle of a transfer
    logic   in_window;
    logic   mapped;
    logic   exc_sticky;

    assign access    = (state == st_idle) && psel && penable;
    assign in_window = (paddr[7:6] == cop_pkg::addr_creg_base[7:6]) && (paddr[1:0] == 2'b00);
    assign mapped    = in_window ||
                       (paddr == cop_pkg::addr_insn)    || (paddr == cop_pkg::addr_gpr_in) ||
                       (paddr == cop_pkg::addr_gpr_out) || (paddr == cop_pkg::addr_status);

    // Command write launches the instruction straight from the bus
    assign insn_valid = access && pwrite && (paddr == cop_pkg::addr_insn);
    assign insn       = pwdata;
    assign dbg_addr   = paddr[5:2];

    // Instruction writes stall until the result stage reports done
    assign pready  = (state == st_wait_done) ? done : (access && !insn_valid);
    assign pslverr = access && !mapped;

    always_comb begin
        prdata = '0;
        if (in_window) begin
            prdata = dbg_data;
        end else begin
            case (paddr)
                cop_pkg::addr_gpr_in:  prdata = gpr_in;
                cop_pkg::addr_gpr_out: prdata = gpr_out;
                cop_pkg::addr_status:  prdata = {31'd0, exc_sticky};
                default:               prdata = '0;
            endcase
        end
    end

    always_ff @(posedge g_clk) begin
        if (reset) begin
            state      <= st_idle;
            gpr_in     <= '0;
            exc_sticky <= 1'b0;
        end else begin
            case (state)
                st_idle:      if (insn_valid) state <= st_wait_done;
                st_wait_done: if (done) state <= st_idle;
                default:      state <= st_idle;
            endcase
            if (access && pwrite && (paddr == cop_pkg::addr_gpr_in)) begin
                gpr_in <= pwdata;
            end
            if (done && exception) begin
                exc_sticky <= 1'b1;    // Held until host clears it
            end else if (access && pwrite && (paddr == cop_pkg::addr_status)) begin
                exc_sticky <= 1'b0;
            end
        end
    end

endmodule

//--- decode/cop_decode.sv
// Instruction decoder
module cop_decode #(
    parameter cop_pkg::pack_mask_t pack_mask = cop_pkg::pack_mask_all
) (
    input  logic              g_clk,
    input  logic              reset,
    input  logic              insn_valid,
    input  cop_pkg::word_t    insn,
    output cop_pkg::decoded_t dec
);

    cop_pkg::opcode_t  opcode;
    cop_pkg::funct_t   funct;
    cop_pkg::pw_t      pw;
    logic              rsvd;
    logic              packed_op;
    logic              bad_opcode;
    logic              bad_funct;
    logic              bad_pw;
    logic              pw_disabled;
    cop_pkg::decoded_t dec_next;

    // Field extraction
    assign opcode = insn[cop_pkg::opcode_hi:cop_pkg::opcode_lo];
    assign funct  = insn[cop_pkg::funct_hi:cop_pkg::funct_lo];
    assign pw     = insn[cop_pkg::pw_hi:cop_pkg::pw_lo];
    assign rsvd   = insn[cop_pkg::rsvd_bit];

    assign packed_op  = (funct <= cop_pkg::f_prot_i);
    assign bad_opcode = (opcode != cop_pkg::op_custom);
    assign bad_funct  = (funct > cop_pkg::f_cmovn);      // Dropped classes land here

    // Pack width checks only matter for the packed class
    assign bad_pw = packed_op && (pw > cop_pkg::pw_2);

    always_comb begin
        pw_disabled = 1'b0;
        if (packed_op && (pw <= cop_pkg::pw_2)) begin
            pw_disabled = !pack_mask[pw];
        end
    end

    always_comb begin
        dec_next           = '0;
        dec_next.valid     = insn_valid;
        dec_next.funct     = funct;
        dec_next.pw        = pw;
        dec_next.crd       = insn[cop_pkg::crd_hi:cop_pkg::crd_lo];
        dec_next.crs1      = insn[cop_pkg::crs1_hi:cop_pkg::crs1_lo];
        dec_next.crs2      = insn[cop_pkg::crs2_hi:cop_pkg::crs2_lo];
        dec_next.imm       = insn[cop_pkg::imm_hi:cop_pkg::imm_lo];
        dec_next.exception = bad_opcode || rsvd || bad_funct || bad_pw || pw_disabled;
    end

    always_ff @(posedge g_clk) begin
        if (reset) begin
            dec <= '0;
        end else begin
            dec <= dec_next;    // One cycle behind the command write
        end
    end

endmodule

//--- execute/cop_execute.sv
// Packed, bitwise and move execution
module cop_execute (
    input  logic              g_clk,
    input  logic              reset,
    input  cop_pkg::decoded_t dec,
    input  cop_pkg::word_t    gpr_in,
    input  cop_pkg::word_t    rd_data1,
    input  cop_pkg::word_t    rd_data2,
    output cop_pkg::creg_t    rd_addr1,
    output cop_pkg::creg_t    rd_addr2,
    output cop_pkg::wb_t      wb
);

    int           lane_w;
    cop_pkg::wb_t wb_next;

    function automatic int lane_width(cop_pkg::pw_t pw);
        case (pw)
            cop_pkg::pw_16: return 16;
            cop_pkg::pw_8:  return 8;
            cop_pkg::pw_4:  return 4;
            cop_pkg::pw_2:  return 2;
            default:        return 32;
        endcase
    endfunction

    // Ripple add with the carry restarted at each lane boundary
    function automatic cop_pkg::word_t lane_addsub(cop_pkg::word_t a, cop_pkg::word_t b,
                                                   int w, logic sub);
        cop_pkg::word_t bb;
        cop_pkg::word_t r;
        logic           c;
        bb = sub ? ~b : b;
        c  = 1'b0;
        for (int i = 0; i < 32; i++) begin
            if ((i & (w - 1)) == 0) c = sub;   // Subtract carries in one at the lane LSB
            r[i] = a[i] ^ bb[i] ^ c;
            c    = (a[i] & bb[i]) | (c & (a[i] ^ bb[i]));
        end
        return r;
    endfunction

    function automatic cop_pkg::word_t lane_shift(cop_pkg::word_t a, int w,
                                                  cop_pkg::imm_t imm, cop_pkg::funct_t op);
        cop_pkg::word_t r;
        int             sh;
        int             base;
        int             pos;
        r  = '0;
        sh = int'(imm) & (w - 1);              // Amount modulo lane width
        for (int i = 0; i < 32; i++) begin
            base = i & ~(w - 1);
            pos  = i & (w - 1);
            if (op == cop_pkg::f_psll_i) begin
                if (pos >= sh) r[i] = a[base + pos - sh];
            end else if (op == cop_pkg::f_psrl_i) begin
                if (pos + sh < w) r[i] = a[base + pos + sh];
            end else begin
                r[i] = a[base + ((pos + sh) & (w - 1))];   // Rotate right
            end
        end
        return r;
    endfunction

    assign rd_addr1 = dec.crs1;
    assign rd_addr2 = dec.crs2;
    assign lane_w   = lane_width(dec.pw);

    always_comb begin
        wb_next           = '0;
        wb_next.valid     = dec.valid;
        wb_next.crd       = dec.crd;
        wb_next.exception = dec.exception;
        case (dec.funct)
            cop_pkg::f_padd, cop_pkg::f_psub: begin
                wb_next.creg_we = 1'b1;
                wb_next.data    = lane_addsub(rd_data1, rd_data2, lane_w,
                                              dec.funct == cop_pkg::f_psub);
            end
            cop_pkg::f_psll_i, cop_pkg::f_psrl_i, cop_pkg::f_prot_i: begin
                wb_next.creg_we = 1'b1;
                wb_next.data    = lane_shift(rd_data1, lane_w, dec.imm, dec.funct);
            end
            cop_pkg::f_bop: begin
                wb_next.creg_we = 1'b1;
                for (int i = 0; i < 32; i++) begin
                    wb_next.data[i] = dec.imm[{1'b0, rd_data1[i], rd_data2[i]}];   // LUT lookup
                end
            end
            cop_pkg::f_gpr2xcr: begin
                wb_next.creg_we = 1'b1;
                wb_next.data    = gpr_in;
            end
            cop_pkg::f_xcr2gpr: begin
                wb_next.gpr_we   = 1'b1;
                wb_next.gpr_data = rd_data1;
            end
            cop_pkg::f_cmov, cop_pkg::f_cmovn: begin
                wb_next.creg_we = (dec.funct == cop_pkg::f_cmov) ? (rd_data2 != '0)
                                                                  : (rd_data2 == '0);
                wb_next.data    = rd_data1;
            end
            default: ;
        endcase
        if (dec.exception) begin
            wb_next.creg_we = 1'b0;    // Illegal words change nothing
            wb_next.gpr_we  = 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb <= wb_next;
        end
    end

endmodule

//--- result/cop_result.sv
// Register file and writeback
module cop_result (
    input  logic           g_clk,
    input  logic           reset,
    input  cop_pkg::wb_t   wb,
    input  cop_pkg::creg_t rd_addr1,
    input  cop_pkg::creg_t rd_addr2,
    input  cop_pkg::creg_t dbg_addr,
    output cop_pkg::word_t rd_data1,
    output cop_pkg::word_t rd_data2,
    output cop_pkg::word_t dbg_data,
    output logic           done,
    output logic           exception,
    output cop_pkg::word_t gpr_out
);

    cop_pkg::word_t regs [cop_pkg::ncreg];

    // Combinational read ports
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];
    assign dbg_data = regs[dbg_addr];   // Host register window

    // Completion seen by the APB port in the writeback cycle
    assign done      = wb.valid;
    assign exception = wb.valid && wb.exception;

    always_ff @(posedge g_clk) begin
        if (reset) begin
            for (int i = 0; i < cop_pkg::ncreg; i++) begin
                regs[i] <= '0;
            end
            gpr_out <= '0;
        end else if (wb.valid) begin
            if (wb.creg_we) begin
                regs[wb.crd] <= wb.data;
            end
            if (wb.gpr_we) begin
                gpr_out <= wb.gpr_data;    // Read back by host at gpr_out
            end
        end
    end

endmodule

//--- source/cop_top.sv
// Crypto coprocessor top
module cop_top #(
    parameter cop_pkg::pack_mask_t pack_mask = cop_pkg::pack_mask_all
) (
    input  logic               g_clk,
    input  logic               reset,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  cop_pkg::apb_addr_t paddr,
    input  cop_pkg::word_t     pwdata,
    output cop_pkg::word_t     prdata,
    output logic               pready,
    output logic               pslverr
);

    logic               insn_valid;
    cop_pkg::word_t     insn;
    cop_pkg::word_t     gpr_in;
    cop_pkg::creg_t     dbg_addr;
    cop_pkg::word_t     dbg_data;
    logic               done;
    logic               exception;
    cop_pkg::word_t     gpr_out;

    cop_pkg::decoded_t  dec;
    cop_pkg::wb_t       wb;
    cop_pkg::creg_t     rd_addr1;
    cop_pkg::creg_t     rd_addr2;
    cop_pkg::word_t     rd_data1;
    cop_pkg::word_t     rd_data2;

    cop_apb_port i_cop_apb_port (
        .g_clk      (g_clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .insn_valid (insn_valid),
        .insn       (insn),
        .gpr_in     (gpr_in),
        .dbg_addr   (dbg_addr),
        .done       (done),
        .exception  (exception),
        .gpr_out    (gpr_out),
        .dbg_data   (dbg_data)
    );

    cop_decode #(.pack_mask(pack_mask)) i_cop_decode (
        .g_clk      (g_clk),
        .reset      (reset),
        .insn_valid (insn_valid),
        .insn       (insn),
        .dec        (dec)
    );

    cop_execute i_cop_execute (
        .g_clk    (g_clk),
        .reset    (reset),
        .dec      (dec),
        .gpr_in   (gpr_in),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .wb       (wb)
    );

    cop_result i_cop_result (
        .g_clk     (g_clk),
        .reset     (reset),
        .wb        (wb),
        .rd_addr1  (rd_addr1),
        .rd_addr2  (rd_addr2),
        .dbg_addr  (dbg_addr),
        .rd_data1  (rd_data1),
        .rd_data2  (rd_data2),
        .dbg_data  (dbg_data),
        .done      (done),
        .exception (exception),
        .gpr_out   (gpr_out)
    );

endmodule

//--- test/tb_cop_vectors.svh
// Instruction test vectors
`ifndef tb_cop_vectors_svh
`define tb_cop_vectors_svh

// Columns are name, load gpr_in, gpr_in value, instruction word,
// register read back (16 reads gpr_out), expected value and expected exception
// enc takes funct, pw, crd, crs1, crs2 and imm
function automatic void fill_table();
    add_vec("ld_r1",      1'b1, 32'h8F7F_FF01, enc(6, 0, 1, 0, 0, 0),  1, 32'h8F7F_FF01, 1'b0);
    add_vec("ld_r2",      1'b1, 32'h7181_0102, enc(6, 0, 2, 0, 0, 0),  2, 32'h7181_0102, 1'b0);
    add_vec("padd32",     1'b0, 32'h0,         enc(0, 0, 4, 1, 2, 0),  4, 32'h0101_0003, 1'b0);
    add_vec("padd16",     1'b0, 32'h0,         enc(0, 1, 4, 1, 2, 0),  4, 32'h0100_0003, 1'b0);
    add_vec("padd8",      1'b0, 32'h0,         enc(0, 2, 4, 1, 2, 0),  4, 32'h0000_0003, 1'b0);
    add_vec("padd4",      1'b0, 32'h0,         enc(0, 3, 4, 1, 2, 0),  4, 32'hF0F0_F003, 1'b0);
    add_vec("psub32",     1'b0, 32'h0,         enc(1, 0, 4, 1, 2, 0),  4, 32'h1DFE_FDFF, 1'b0);
    add_vec("psub16",     1'b0, 32'h0,         enc(1, 1, 4, 1, 2, 0),  4, 32'h1DFE_FDFF, 1'b0);
    add_vec("psub8",      1'b0, 32'h0,         enc(1, 2, 4, 1, 2, 0),  4, 32'h1EFE_FEFF, 1'b0);
    add_vec("psub4",      1'b0, 32'h0,         enc(1, 3, 4, 1, 2, 0),  4, 32'h1EFE_FE0F, 1'b0);
    add_vec("psll8_3",    1'b0, 32'h0,         enc(2, 2, 4, 1, 0, 3),  4, 32'h78F8_F808, 1'b0);
    add_vec("psrl8_3",    1'b0, 32'h0,         enc(3, 2, 4, 1, 0, 3),  4, 32'h110F_1F00, 1'b0);
    add_vec("prot8_11",   1'b0, 32'h0,         enc(4, 2, 4, 1, 0, 11), 4, 32'hF1EF_FF20, 1'b0);
    add_vec("psll2_1",    1'b0, 32'h0,         enc(2, 4, 4, 1, 0, 1),  4, 32'h0AAA_AA02, 1'b0);
    add_vec("psrl2_1",    1'b0, 32'h0,         enc(3, 4, 4, 1, 0, 1),  4, 32'h4515_5500, 1'b0);
    add_vec("prot2_5",    1'b0, 32'h0,         enc(4, 4, 4, 1, 0, 5),  4, 32'h4FBF_FF02, 1'b0);
    add_vec("bop_and",    1'b0, 32'h0,         enc(5, 0, 4, 1, 2, 8),  4, 32'h0101_0100, 1'b0);
    add_vec("bop_xor",    1'b0, 32'h0,         enc(5, 0, 4, 1, 2, 6),  4, 32'hFEFE_FE03, 1'b0);
    add_vec("bop_or",     1'b0, 32'h0,         enc(5, 0, 4, 1, 2, 14), 4, 32'hFFFF_FF03, 1'b0);
    add_vec("cmov_nz",    1'b0, 32'h0,         enc(8, 0, 5, 1, 2, 0),  5, 32'h8F7F_FF01, 1'b0);
    add_vec("cmov_z",     1'b0, 32'h0,         enc(8, 0, 7, 1, 0, 0),  7, 32'h0000_0000, 1'b0);
    add_vec("cmovn_z",    1'b0, 32'h0,         enc(9, 0, 6, 1, 0, 0),  6, 32'h8F7F_FF01, 1'b0);
    add_vec("cmovn_nz",   1'b0, 32'h0,         enc(9, 0, 7, 1, 2, 0),  7, 32'h0000_0000, 1'b0);
    add_vec("xcr2gpr",    1'b0, 32'h0,         enc(7, 0, 0, 2, 0, 0), 16, 32'h7181_0102, 1'b0);
    add_vec("bad_funct",  1'b0, 32'h0,         enc(10, 0, 1, 1, 2, 0), 1, 32'h8F7F_FF01, 1'b1);
    // Opcode bit 6 flipped
    add_vec("bad_opcode", 1'b1, 32'hDEAD_BEEF, enc(6, 0, 2, 0, 0, 0) ^ 32'h40,
            2, 32'h7181_0102, 1'b1);
    add_vec("bad_pw6",    1'b0, 32'h0,         enc(0, 6, 1, 1, 2, 0),  1, 32'h8F7F_FF01, 1'b1);
endfunction

`endif

//--- test/tb_cop.sv
// Coprocessor testbench
module tb_cop;

    localparam int n_random = 8;

    typedef struct packed {
        logic           use_gpr;
        cop_pkg::word_t gpr;
        cop_pkg::word_t insn;
        logic [4:0]     check;      // Register index or 16 for gpr_out
        cop_pkg::word_t exp;
        logic           exc;
    } vector_t;

    logic               g_clk;
    logic               reset;
    logic               psel;
    logic               penable;
    logic               pwrite;
    cop_pkg::apb_addr_t paddr;
    cop_pkg::word_t     pwdata;
    cop_pkg::word_t     prdata;
    logic               pready;
    logic               pslverr;

    string          name_q[$];
    vector_t        vec_q[$];
    int             errors;
    int             cycle_count;
    int             timeout_limit;
    cop_pkg::word_t rng;

    cop_top #(.pack_mask(cop_pkg::pack_mask_all)) i_cop_top (
        .g_clk   (g_clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;
    end

    function automatic cop_pkg::word_t xorshift(input cop_pkg::word_t x);
        cop_pkg::word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Instruction word from its fields
    function automatic cop_pkg::word_t enc(input int funct, input int pw, input int crd,
                                           input int crs1, input int crs2, input int imm);
        cop_pkg::word_t w;
        w        = '0;
        w[6:0]   = 7'b0001011;
        w[10:7]  = crd[3:0];
        w[14:12] = pw[2:0];
        w[18:15] = crs1[3:0];
        w[22:19] = crs2[3:0];
        w[27:23] = imm[4:0];
        w[31:28] = funct[3:0];
        return w;
    endfunction

    function automatic void add_vec(input string name, input bit use_gpr,
                                    input cop_pkg::word_t gpr, input cop_pkg::word_t insn,
                                    input int check, input cop_pkg::word_t exp, input bit exc);
        vector_t v;
        v.use_gpr = use_gpr;
        v.gpr     = gpr;
        v.insn    = insn;
        v.check   = check[4:0];
        v.exp     = exp;
        v.exc     = exc;
        name_q.push_back(name);
        vec_q.push_back(v);
    endfunction

    `include "tb_cop_vectors.svh"

    function automatic void expect_equal(input string name, input cop_pkg::word_t exp,
                                         input cop_pkg::word_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endfunction

    // Four control registers and a window of sixteen words
    function automatic bit addr_mapped(input cop_pkg::apb_addr_t addr);
        return (addr inside {8'h00, 8'h04, 8'h08, 8'h0C}) ||
               ((addr >= 8'h40) && (addr <= 8'h7C) && (addr[1:0] == 2'b00));
    endfunction

    // One APB transfer with inputs changed on the falling edge
    task automatic apb_access(input bit write, input cop_pkg::apb_addr_t addr,
                              input cop_pkg::word_t wdata, output cop_pkg::word_t rdata);
        int access_cycles;
        @(negedge g_clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge g_clk);
        penable       = 1'b1;
        access_cycles = 1;
        #1;
        while (!pready) begin
            @(negedge g_clk);
            #1;
            access_cycles++;
        end
        rdata = prdata;     // Stable before the completing edge
        expect_equal($sformatf("pslverr_%h", addr), cop_pkg::word_t'(!addr_mapped(addr)),
                     cop_pkg::word_t'(pslverr));
        if (write && addr == cop_pkg::addr_insn) begin
            expect_equal("insn_access_cycles", 32'd3, cop_pkg::word_t'(access_cycles));
        end
        @(negedge g_clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input cop_pkg::apb_addr_t addr, input cop_pkg::word_t data);
        cop_pkg::word_t ignored;
        apb_access(1'b1, addr, data, ignored);
    endtask

    task automatic apb_read(input cop_pkg::apb_addr_t addr, output cop_pkg::word_t data);
        apb_access(1'b0, addr, '0, data);
    endtask

    initial begin
        cycle_count = 0;
        wait (timeout_limit > 0);
        while (cycle_count < timeout_limit) begin
            @(posedge g_clk);
            cycle_count++;
        end
        $display("Timeout: run still busy after %0d clock cycles", cycle_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        vector_t            v;
        cop_pkg::word_t     rd;
        cop_pkg::word_t     val;
        cop_pkg::apb_addr_t addr;
        logic [3:0]         r;
        errors        = 0;
        timeout_limit = 0;
        rng           = 32'hef12;
        reset         = 1'b1;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        fill_table();
        timeout_limit = (vec_q.size() + 2 * n_random) * 4 * 8 + 100;
        repeat (5) @(negedge g_clk);
        reset = 1'b0;

        for (int i = 0; i < vec_q.size(); i++) begin
            v = vec_q[i];
            if (v.use_gpr) begin
                apb_write(cop_pkg::addr_gpr_in, v.gpr);
            end
            apb_write(cop_pkg::addr_insn, v.insn);
            if (v.check == 5'd16) begin
                addr = cop_pkg::addr_gpr_out;
            end else begin
                addr = cop_pkg::apb_addr_t'(cop_pkg::addr_creg_base + 4 * v.check);
            end
            apb_read(addr, rd);
            expect_equal(name_q[i], v.exp, rd);
            apb_read(cop_pkg::addr_status, rd);
            expect_equal({name_q[i], "_status"}, {31'd0, v.exc}, rd);
            if (v.exc) begin
                apb_write(cop_pkg::addr_status, '0);     // Clear sticky flag
                apb_read(cop_pkg::addr_status, rd);
                expect_equal({name_q[i], "_clear"}, '0, rd);
            end
        end

        // gpr_in to a random register and back out through gpr_out
        for (int k = 0; k < n_random; k++) begin
            rng = xorshift(rng);
            val = rng;
            rng = xorshift(rng);
            r   = rng[3:0];
            apb_write(cop_pkg::addr_gpr_in, val);
            apb_write(cop_pkg::addr_insn, enc(6, 0, int'(r), 0, 0, 0));
            apb_write(cop_pkg::addr_insn, enc(7, 0, 0, int'(r), 0, 0));
            apb_read(cop_pkg::addr_gpr_out, rd);
            expect_equal($sformatf("round_trip_%0d", k), val, rd);
        end

        // Hole between the status register and the window
        apb_read(8'h10, rd);

        $display("Finished %0d vectors and %0d round trips with %0d errors",
                 vec_q.size(), n_random, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+test
common/cop_pkg.sv
source/cop_apb_port.sv
decode/cop_decode.sv
execute/cop_execute.sv
result/cop_result.sv
source/cop_top.sv
test/tb_cop.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the coprocessor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_cop -o tb_cop

# Output is kept in memory and searched for the pass line
sim_output=$(./obj_dir/tb_cop)
echo "$sim_output"

if grep -qF "*** TEST PASSED ***" <<< "$sim_output"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
